//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/rv_core_properties.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_properties import rv_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input wire logic      clk_i,
  input wire logic      reset_i,
  input wire word_t     imem_addr_o,
  input wire logic      retire_valid_o,
  input wire reg_addr_t retire_rd_o
);

  ////////////////////
  // reset behavior

  assert property (@(posedge clk_i) reset_i |=> !retire_valid_o)
    else $error("retire pulse right after a reset cycle");

  assert property (@(posedge clk_i) $fell(reset_i) |-> imem_addr_o == RESET_PC)
    else $error("first fetch address differs from RESET_PC");

  // pipeline is empty for five cycles after reset
  assert property (@(posedge clk_i) $past(reset_i, 5) |-> !retire_valid_o)
    else $error("retire pulse before the first instruction could finish");

  ////////////////////
  // retire port

  // x31 is only written on flushed paths
  assert property (@(posedge clk_i) disable iff (reset_i)
                   retire_valid_o |-> retire_rd_o != 5'd31)
    else $error("flushed instruction retired to x31");

  assert property (@(posedge clk_i) disable iff (reset_i)
                   retire_valid_o |-> retire_rd_o != 5'd0)
    else $error("write to x0 produced a retire pulse");

endmodule

bind rv_core rv_core_properties #(
  .RESET_PC (RESET_PC)
) properties_inst (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .imem_addr_o    (imem_addr_o),
  .retire_valid_o (retire_valid_o),
  .retire_rd_o    (retire_rd_o)
);

`default_nettype wire

//--- bench/rv_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

  typedef struct packed {
    reg_addr_t rd;
    word_t     data;
  } retire_s;

  localparam word_t  RESET_PC = 32'h0;
  localparam instr_t NOP      = 32'h0000_0013;
  localparam int     TIMEOUT  = 400;

  ////////////////////
  // instruction encoders

  function automatic instr_t op_imm(input int f3, input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'h13};
  endfunction

  function automatic instr_t op_reg(input int f7, input int f3, input int rd, input int rs1,
                                    input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic instr_t lui(input int rd, input int imm);
    return {imm[19:0], rd[4:0], 7'h37};
  endfunction

  function automatic instr_t branch(input int f3, input int rs1, input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
  endfunction

  function automatic instr_t jal(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6F};
  endfunction

  function automatic retire_s wr(input int rd, input word_t data);
    return {rd[4:0], data};
  endfunction

  // x1 = 5 and x2 = -3 feed most of the compares below
  localparam instr_t PROGRAM [44] = '{
    op_imm(0, 1, 0, 5),        op_imm(0, 2, 0, -3),      op_reg(0, 0, 3, 1, 2),
    op_reg(32, 0, 4, 3, 1),    op_reg(0, 2, 5, 2, 1),    op_reg(0, 3, 6, 2, 1),
    op_imm(2, 7, 2, -2),       op_imm(3, 8, 1, -1),      op_imm(4, 9, 1, 'hF0),
    op_imm(6, 10, 9, 'h300),   op_imm(7, 11, 10, 'hFF),  op_imm(1, 12, 1, 4),
    op_imm(5, 13, 2, 'h401),   lui(14, 'h80000),         op_reg(32, 5, 15, 14, 1),
    op_reg(0, 5, 16, 14, 1),   op_reg(0, 1, 17, 1, 1),   op_reg(0, 4, 18, 9, 10),
    op_reg(0, 6, 19, 9, 12),   op_reg(0, 7, 20, 10, 2),  op_imm(0, 0, 1, 7),
    // taken branches with a marker write to x31 in each shadow
    branch(0, 1, 1, 8),        op_imm(0, 31, 0, 1),      branch(1, 1, 2, 8),
    op_imm(0, 31, 0, 1),       branch(4, 2, 1, 8),       op_imm(0, 31, 0, 1),
    branch(5, 1, 2, 8),        op_imm(0, 31, 0, 1),      branch(6, 1, 2, 8),
    op_imm(0, 31, 0, 1),       branch(7, 2, 1, 8),       op_imm(0, 31, 0, 1),
    // not taken
    branch(0, 1, 2, 8),        branch(1, 1, 1, 8),       branch(4, 1, 2, 8),
    branch(5, 2, 1, 8),        branch(6, 2, 1, 8),       branch(7, 1, 2, 8),
    op_imm(0, 21, 0, 21),      jal(22, 8),               op_imm(0, 31, 0, 1),
    op_imm(0, 23, 22, 1),      jal(0, 0)
  };

  localparam int WRITES = 23;
  localparam retire_s EXPECTED [WRITES] = '{
    wr(1, 32'h0000_0005),  wr(2, 32'hFFFF_FFFD),  wr(3, 32'h0000_0002),
    wr(4, 32'hFFFF_FFFD),  wr(5, 32'h0000_0001),  wr(6, 32'h0000_0000),
    wr(7, 32'h0000_0001),  wr(8, 32'h0000_0001),  wr(9, 32'h0000_00F5),
    wr(10, 32'h0000_03F5), wr(11, 32'h0000_00F5), wr(12, 32'h0000_0050),
    wr(13, 32'hFFFF_FFFE), wr(14, 32'h8000_0000), wr(15, 32'hFC00_0000),
    wr(16, 32'h0400_0000), wr(17, 32'h0000_00A0), wr(18, 32'h0000_0300),
    wr(19, 32'h0000_00F5), wr(20, 32'h0000_03F5), wr(21, 32'h0000_0015),
    wr(22, 32'h0000_00A4), wr(23, 32'h0000_00A5)
  };

  logic      clk_i;
  logic      reset_i;
  word_t     imem_addr;
  instr_t    imem_data;
  logic      retire_valid;
  reg_addr_t retire_rd;
  word_t     retire_data;
  int        write_index;
  int        cycle_count;
  retire_s   expected;

  rv_core #(
    .RESET_PC (RESET_PC)
  ) rv_core_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .imem_addr_o    (imem_addr),
    .imem_data_i    (imem_data),
    .retire_valid_o (retire_valid),
    .retire_rd_o    (retire_rd),
    .retire_data_o  (retire_data)
  );

  function automatic instr_t rom_read(input word_t addr);
    instr_t data;
    data = NOP;
    if ((addr[31:8] == '0) && (addr[7:2] < 6'd44)) begin
      data = PROGRAM[addr[7:2]];
    end
    return data;
  endfunction

  function automatic retire_s expected_at(input int idx);
    retire_s entry;
    entry = '0;
    if (idx < WRITES) begin
      entry = EXPECTED[idx];
    end
    return entry;
  endfunction

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  assign imem_data = rom_read(imem_addr);
  assign expected  = expected_at(write_index);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      write_index <= 0;
    end else if (retire_valid) begin
      write_index <= write_index + 1;
    end
  end

  ////////////////////
  // retire checks

  assert property (@(posedge clk_i) disable iff (reset_i)
                   retire_valid |-> write_index < WRITES)
    else begin
      $display("more register writes retired than the program makes");
      abort_run();
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
                   retire_valid |-> retire_rd == expected.rd)
    else begin
      $display("error retire_rd_o expected %h actual %h",
               $sampled(expected.rd), $sampled(retire_rd));
      abort_run();
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
                   retire_valid |-> retire_data == expected.data)
    else begin
      $display("error retire_data_o expected %h actual %h",
               $sampled(expected.data), $sampled(retire_data));
      abort_run();
    end

  // cycle limit
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT) begin
      $display("timeout, only %0d of %0d writes retired", write_index, WRITES);
      abort_run();
    end
  end

  initial begin
    reset_i = 1'b1;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    while (write_index < WRITES) begin
      @(posedge clk_i);
    end
    // idle window so a late stray write still trips the checks
    repeat (20) @(posedge clk_i);
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
rtl/rv_pkg.sv
rtl/rv_regfile.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_operand_fetch.sv
rtl/rv_execute.sv
rtl/rv_writeback.sv
rtl/rv_core.sv
bench/rv_core_properties.sv
bench/rv_core_tb.sv

//--- rtl/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core import rv_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  wire logic   clk_i,
  input  wire logic   reset_i,
  output word_t       imem_addr_o,
  input  wire instr_t imem_data_i,
  output logic        retire_valid_o,
  output reg_addr_t   retire_rd_o,
  output word_t       retire_data_o
);

  fetch_s    prefetch;
  decode_s   decode_bundle;
  decode_s   opf_bundle;
  word_t     rs1_val;
  word_t     rs2_val;
  exec_s     exec_result;
  redirect_s jal_redirect;
  redirect_s branch_redirect;
  logic      wb_valid;
  reg_addr_t wb_rd;
  word_t     wb_data;

  ////////////////////
  // front end

  rv_fetch #(
    .RESET_PC (RESET_PC)
  ) fetch_inst (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .imem_data_i       (imem_data_i),
    .jal_redirect_i    (jal_redirect),
    .branch_redirect_i (branch_redirect),
    .imem_addr_o       (imem_addr_o),
    .fetch_o           (prefetch)
  );

  rv_decode decode_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fetch_i        (prefetch),
    .flush_i        (branch_redirect.valid),
    .decode_o       (decode_bundle),
    .jal_redirect_o (jal_redirect)
  );

  ////////////////////
  // back end

  rv_operand_fetch operand_fetch_inst (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .decode_i   (decode_bundle),
    .flush_i    (branch_redirect.valid),
    .wb_valid_i (wb_valid),
    .wb_rd_i    (wb_rd),
    .wb_data_i  (wb_data),
    .opf_o      (opf_bundle),
    .rs1_val_o  (rs1_val),
    .rs2_val_o  (rs2_val)
  );

  rv_execute execute_inst (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .opf_i      (opf_bundle),
    .rs1_val_i  (rs1_val),
    .rs2_val_i  (rs2_val),
    .flush_i    (branch_redirect.valid),
    .wb_valid_i (wb_valid),
    .wb_rd_i    (wb_rd),
    .wb_data_i  (wb_data),
    .exec_o     (exec_result)
  );

  rv_writeback writeback_inst (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .exec_i            (exec_result),
    .wb_valid_o        (wb_valid),
    .wb_rd_o           (wb_rd),
    .wb_data_o         (wb_data),
    .branch_redirect_o (branch_redirect),
    .retire_valid_o    (retire_valid_o),
    .retire_rd_o       (retire_rd_o),
    .retire_data_o     (retire_data_o)
  );

endmodule

`default_nettype wire

//--- rtl/rv_decode.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decode import rv_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      reset_i,
  input  wire fetch_s    fetch_i,
  input  wire logic      flush_i,
  output decode_s        decode_o,
  output redirect_s      jal_redirect_o
);

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  instr_t     instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_u;
  word_t      imm_b;
  word_t      imm_j;
  logic       legal;
  logic       is_jal;
  decode_s    dec;

  // shared by op and op-imm, alt picks sub or sra
  function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign instr  = fetch_i.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // immediate formats
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec           = '0;
    dec.pc        = fetch_i.pc;
    dec.rs1       = instr[19:15];
    dec.rs2       = instr[24:20];
    dec.rd        = instr[11:7];
    dec.link_data = fetch_i.pc + 32'd4;
    dec.alu_op    = ALU_ADD;
    dec.branch_cond = BR_EQ;
    legal         = 1'b1;
    is_jal        = 1'b0;
    case (opcode)
      OPC_OP_IMM: begin
        dec.rs2     = '0;
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        // funct7 is immediate data except on the right shifts
        dec.alu_op  = alu_from_funct(funct3, (funct3 == 3'b101) && funct7[5]);
      end
      OPC_OP: begin
        dec.alu_op = alu_from_funct(funct3, funct7[5]);
        legal = (funct7 == 7'b0000000) ||
                ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
      end
      OPC_LUI: begin
        dec.rs1     = '0;
        dec.rs2     = '0;
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
        dec.alu_op  = ALU_PASS_B;
      end
      OPC_JAL: begin
        dec.rs1     = '0;
        dec.rs2     = '0;
        dec.imm     = imm_j;
        dec.is_link = 1'b1;
        is_jal      = 1'b1;
      end
      OPC_BRANCH: begin
        // rd bits hold the immediate here, keep them out of forwarding
        dec.rd          = '0;
        dec.imm         = imm_b;
        dec.is_branch   = 1'b1;
        dec.branch_cond = branch_cond_e'(funct3);
        legal           = funct3[2] | ~funct3[1];
      end
      default: begin
        legal = 1'b0;
      end
    endcase
    // unknown encodings become bubbles
    dec.valid = fetch_i.valid & legal & ~flush_i & ~jal_redirect_o.valid;
  end

  ////////////////////
  // decode register

  always_ff @(posedge clk_i) begin
    decode_o              <= dec;
    jal_redirect_o.target <= fetch_i.pc + imm_j;
    if (reset_i) begin
      decode_o.valid       <= 1'b0;
      jal_redirect_o.valid <= 1'b0;
    end else begin
      jal_redirect_o.valid <= dec.valid & is_jal;
    end
  end

endmodule

`default_nettype wire

//--- rtl/rv_execute.sv
`timescale 1ns/10ps
`default_nettype none

module rv_execute import rv_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      reset_i,
  input  wire decode_s   opf_i,
  input  wire word_t     rs1_val_i,
  input  wire word_t     rs2_val_i,
  input  wire logic      flush_i,
  input  wire logic      wb_valid_i,
  input  wire reg_addr_t wb_rd_i,
  input  wire word_t     wb_data_i,
  output exec_s          exec_o
);

  word_t op_a;
  word_t op_b;
  word_t fwd_rs2;
  word_t alu_result;

  // youngest producer first: execute result, then writeback
  function automatic word_t forward(input reg_addr_t src, input word_t reg_val,
                                    input exec_s ex, input logic wb_v,
                                    input reg_addr_t wb_rd, input word_t wb_data);
    word_t value;
    if (ex.valid && (ex.rd != '0) && (ex.rd == src)) begin
      value = ex.result;
    end else if (wb_v && (wb_rd != '0) && (wb_rd == src)) begin
      value = wb_data;
    end else begin
      value = reg_val;
    end
    return value;
  endfunction

  always_comb begin
    op_a    = forward(opf_i.rs1, rs1_val_i, exec_o, wb_valid_i, wb_rd_i, wb_data_i);
    fwd_rs2 = forward(opf_i.rs2, rs2_val_i, exec_o, wb_valid_i, wb_rd_i, wb_data_i);
    op_b    = opf_i.use_imm ? opf_i.imm : fwd_rs2;
  end

  ////////////////////
  // alu

  always_comb begin
    case (opf_i.alu_op)
      ALU_ADD:    alu_result = op_a + op_b;
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_SLL:    alu_result = op_a << op_b[4:0];
      ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_result = {31'b0, op_a < op_b};
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_SRL:    alu_result = op_a >> op_b[4:0];
      ALU_SRA:    alu_result = word_t'($signed(op_a) >>> op_b[4:0]);
      ALU_OR:     alu_result = op_a | op_b;
      ALU_AND:    alu_result = op_a & op_b;
      default:    alu_result = op_b;
    endcase
  end

  ////////////////////
  // execute register

  always_ff @(posedge clk_i) begin
    exec_o.rd            <= opf_i.rd;
    exec_o.result        <= opf_i.is_link ? opf_i.link_data : alu_result;
    exec_o.is_branch     <= opf_i.is_branch;
    exec_o.branch_cond   <= opf_i.branch_cond;
    exec_o.branch_target <= opf_i.pc + opf_i.imm;
    // flags for the branch decision in writeback
    exec_o.eq            <= op_a == op_b;
    exec_o.lt            <= $signed(op_a) < $signed(op_b);
    exec_o.ltu           <= op_a < op_b;
    if (reset_i | flush_i) begin
      exec_o.valid <= 1'b0;
    end else begin
      exec_o.valid <= opf_i.valid;
    end
  end

endmodule

`default_nettype wire

//--- rtl/rv_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module rv_fetch import rv_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  wire logic      clk_i,
  input  wire logic      reset_i,
  input  wire instr_t    imem_data_i,
  input  wire redirect_s jal_redirect_i,
  input  wire redirect_s branch_redirect_i,
  output word_t          imem_addr_o,
  output fetch_s         fetch_o
);

  word_t pc_q;
  word_t pc_next;

  assign imem_addr_o = pc_q;

  // branch from writeback is older than a jal in decode, so it wins
  always_comb begin
    if (branch_redirect_i.valid) begin
      pc_next = branch_redirect_i.target;
    end else if (jal_redirect_i.valid) begin
      pc_next = jal_redirect_i.target;
    end else begin
      pc_next = pc_q + 32'd4;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  ////////////////////
  // prefetch register

  always_ff @(posedge clk_i) begin
    fetch_o.pc    <= pc_q;
    fetch_o.instr <= imem_data_i;
    if (reset_i) begin
      fetch_o.valid <= 1'b0;
    end else begin
      // word fetched in a redirect cycle is on the wrong path
      fetch_o.valid <= ~(branch_redirect_i.valid | jal_redirect_i.valid);
    end
  end

endmodule

`default_nettype wire

//--- rtl/rv_operand_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module rv_operand_fetch import rv_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      reset_i,
  input  wire decode_s   decode_i,
  input  wire logic      flush_i,
  input  wire logic      wb_valid_i,
  input  wire reg_addr_t wb_rd_i,
  input  wire word_t     wb_data_i,
  output decode_s        opf_o,
  output word_t          rs1_val_o,
  output word_t          rs2_val_o
);

  word_t rs1_val;
  word_t rs2_val;

  rv_regfile regfile_inst (
    .clk_i      (clk_i),
    .rs1_addr_i (decode_i.rs1),
    .rs2_addr_i (decode_i.rs2),
    .wr_en_i    (wb_valid_i),
    .wr_addr_i  (wb_rd_i),
    .wr_data_i  (wb_data_i),
    .rs1_o      (rs1_val),
    .rs2_o      (rs2_val)
  );

  ////////////////////
  // opfetch register

  always_ff @(posedge clk_i) begin
    opf_o     <= decode_i;
    rs1_val_o <= rs1_val;
    rs2_val_o <= rs2_val;
    if (reset_i | flush_i) begin
      opf_o.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [31:0]     instr_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // values follow the funct3 field of the branch opcode
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_cond_e;

  typedef struct packed {
    logic   valid;
    word_t  pc;
    instr_t instr;
  } fetch_s;

  typedef struct packed {
    logic         valid;
    word_t        pc;
    reg_addr_t    rs1;
    reg_addr_t    rs2;
    reg_addr_t    rd;
    word_t        imm;
    logic         use_imm;
    alu_op_e      alu_op;
    logic         is_branch;
    branch_cond_e branch_cond;
    logic         is_link;
    word_t        link_data;
  } decode_s;

  typedef struct packed {
    logic         valid;
    reg_addr_t    rd;
    word_t        result;
    logic         is_branch;
    branch_cond_e branch_cond;
    word_t        branch_target;
    logic         eq;
    logic         lt;
    logic         ltu;
  } exec_s;

  typedef struct packed {
    logic  valid;
    word_t target;
  } redirect_s;

endpackage

`default_nettype wire

//--- rtl/rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  wire logic      clk_i,
  input  wire reg_addr_t rs1_addr_i,
  input  wire reg_addr_t rs2_addr_i,
  input  wire logic      wr_en_i,
  input  wire reg_addr_t wr_addr_i,
  input  wire word_t     wr_data_i,
  output word_t          rs1_o,
  output word_t          rs2_o
);

  word_t regs [32];

  // x0 reads zero, a register being written returns the new value
  function automatic word_t read_port(input reg_addr_t addr, input word_t stored);
    word_t value;
    if (addr == '0) begin
      value = '0;
    end else if (wr_en_i && (wr_addr_i == addr)) begin
      value = wr_data_i;
    end else begin
      value = stored;
    end
    return value;
  endfunction

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  always_comb begin
    rs1_o = read_port(rs1_addr_i, regs[rs1_addr_i]);
    rs2_o = read_port(rs2_addr_i, regs[rs2_addr_i]);
  end

endmodule

`default_nettype wire

//--- rtl/rv_writeback.sv
`timescale 1ns/10ps
`default_nettype none

module rv_writeback import rv_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  reset_i,
  input  wire exec_s exec_i,
  output logic       wb_valid_o,
  output reg_addr_t  wb_rd_o,
  output word_t      wb_data_o,
  output redirect_s  branch_redirect_o,
  output logic       retire_valid_o,
  output reg_addr_t  retire_rd_o,
  output word_t      retire_data_o
);

  logic taken;
  logic accept;

  always_comb begin
    case (exec_i.branch_cond)
      BR_EQ:   taken = exec_i.eq;
      BR_NE:   taken = ~exec_i.eq;
      BR_LT:   taken = exec_i.lt;
      BR_GE:   taken = ~exec_i.lt;
      BR_LTU:  taken = exec_i.ltu;
      default: taken = ~exec_i.ltu;
    endcase
  end

  // the instruction right behind a taken branch is still in execute
  assign accept = exec_i.valid & ~branch_redirect_o.valid;

  always_ff @(posedge clk_i) begin
    wb_rd_o                  <= exec_i.rd;
    wb_data_o                <= exec_i.result;
    branch_redirect_o.target <= exec_i.branch_target;
    if (reset_i) begin
      wb_valid_o              <= 1'b0;
      branch_redirect_o.valid <= 1'b0;
    end else begin
      wb_valid_o              <= accept & ~exec_i.is_branch & (exec_i.rd != '0);
      branch_redirect_o.valid <= accept & exec_i.is_branch & taken;
    end
  end

  // retire port mirrors the register write
  assign retire_valid_o = wb_valid_o;
  assign retire_rd_o    = wb_rd_o;
  assign retire_data_o  = wb_data_o;

endmodule

`default_nettype wire
